//--- source/icache_defines.svh
////////////////////////////////////////////////////////////////////////////
// geometry and width macros of the instruction cache
////////////////////////////////////////////////////////////////////////////

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// associativity and number of sets
`define ICACHE_WAYS        4
`define ICACHE_SETS        16
// bytes per line
// one refill beat carries the whole line
`define ICACHE_LINE_BYTES  16
`define ICACHE_PADDR_WIDTH 16
`define ICACHE_FETCH_WIDTH 32
// random replacement state
`define ICACHE_LFSR_WIDTH  8

// derived address split
`define ICACHE_LINE_WIDTH   (`ICACHE_LINE_BYTES * 8)
`define ICACHE_OFFSET_WIDTH $clog2(`ICACHE_LINE_BYTES)
`define ICACHE_INDEX_WIDTH  $clog2(`ICACHE_SETS)
`define ICACHE_TAG_WIDTH    (`ICACHE_PADDR_WIDTH - `ICACHE_INDEX_WIDTH - `ICACHE_OFFSET_WIDTH)
`define ICACHE_WAY_WIDTH    $clog2(`ICACHE_WAYS)

`endif

//--- source/icache_pkg.sv
////////////////////////////////////////////////////////////////////////////
// address fields, way types, controller states and array controls
////////////////////////////////////////////////////////////////////////////

`include "icache_defines.svh"

package icache_pkg;

  // address and its fields
  typedef logic [`ICACHE_PADDR_WIDTH-1:0]  paddr_t;
  typedef logic [`ICACHE_TAG_WIDTH-1:0]    tag_t;
  typedef logic [`ICACHE_INDEX_WIDTH-1:0]  index_t;
  typedef logic [`ICACHE_OFFSET_WIDTH-1:0] offset_t;

  // payload
  typedef logic [`ICACHE_LINE_WIDTH-1:0]   line_t;
  typedef logic [`ICACHE_FETCH_WIDTH-1:0]  word_t;

  // way number and one bit per way
  typedef logic [`ICACHE_WAY_WIDTH-1:0]    way_idx_t;
  typedef logic [`ICACHE_WAYS-1:0]         way_vec_t;

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} ctrl_state_e;

  // controller to array and replacement
  typedef struct packed {
    logic    rd_en;
    logic    wr_en;
    logic    flush_en;
    logic    inv_en;
    // compare against the tag read in the previous cycle
    logic    cmp_en;
    index_t  index;
    tag_t    tag;
    offset_t offset;
    index_t  flush_idx;
  } arr_ctrl_t;

endpackage

//--- source/icache_mem_pkg.sv
////////////////////////////////////////////////////////////////////////////
// refill request and return beat of the memory side
////////////////////////////////////////////////////////////////////////////

package icache_mem_pkg;

  // kind of return beat
  typedef enum logic {IFILL, INV} rtrn_type_e;

  // refill request
  // line aligned when cacheable and word aligned when not
  typedef struct packed {
    icache_pkg::paddr_t   paddr;
    logic                 nc;
    icache_pkg::way_idx_t way;
  } mem_req_t;

  // return beat
  typedef struct packed {
    rtrn_type_e           rtype;
    icache_pkg::line_t    data;
    // drop all ways of inv_idx
    logic                 inv_all;
    // drop only inv_way of inv_idx
    logic                 inv_one;
    icache_pkg::way_idx_t inv_way;
    icache_pkg::index_t   inv_idx;
  } mem_rtrn_t;

endpackage

//--- source/icache_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// cache controller with flush sequencing and hit or miss handling
// also builds the array controls and the refill request
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "icache_defines.svh"

module icache_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      en_i,
  input  logic                      flush_i,
  input  logic                      fetch_req_i,
  input  icache_pkg::paddr_t        fetch_paddr_i,
  input  logic                      hit_i,
  input  icache_pkg::way_idx_t      repl_way_i,
  input  logic                      mem_ack_i,
  input  logic                      mem_rtrn_vld_i,
  input  icache_mem_pkg::mem_rtrn_t mem_rtrn_i,
  output icache_pkg::arr_ctrl_t     arr_ctrl_o,
  output logic                      fetch_ready_o,
  output logic                      fetch_valid_o,
  output logic                      mem_req_o,
  output icache_mem_pkg::mem_req_t  mem_req_data_o,
  output logic                      miss_o,
  output logic                      busy_o
);

  import icache_pkg::*;
  import icache_mem_pkg::*;

  localparam int unsigned TagLsb = `ICACHE_INDEX_WIDTH + `ICACHE_OFFSET_WIDTH;
  localparam int unsigned NcBit  = `ICACHE_PADDR_WIDTH - 1;

  ctrl_state_e state_d, state_q;
  // registered cache enable
  logic        cache_en_d, cache_en_q;
  // flush request waiting for idle
  logic        flush_d, flush_q;
  index_t      flush_cnt_d, flush_cnt_q;
  logic        flush_en, flush_done, goto_flush;
  // tag compare happens one cycle after the array read
  logic        cmp_en_d, cmp_en_q;
  // invalidation seen in the previous cycle
  logic        inv_en, inv_q;
  logic        ifill_vld;
  logic        rd_en, wr_en, take;
  paddr_t      paddr_d, paddr_q;
  logic        nc_d, nc_q;

  ////////////////////////////////////////////////////////////////////////////
  // return beats and fetch address
  ////////////////////////////////////////////////////////////////////////////

  assign inv_en    = mem_rtrn_vld_i & (mem_rtrn_i.rtype == INV);
  assign ifill_vld = mem_rtrn_vld_i & (mem_rtrn_i.rtype == IFILL);

  assign take    = fetch_ready_o & fetch_req_i;
  assign paddr_d = take ? fetch_paddr_i : paddr_q;
  // io space on the top address bit or cache switched off
  assign nc_d    = take ? (~cache_en_d | fetch_paddr_i[NcBit]) : nc_q;

  // flush walks every set once
  assign flush_done  = (flush_cnt_q == index_t'(`ICACHE_SETS - 1));
  assign flush_cnt_d = flush_en ? flush_cnt_q + index_t'(1) : '0;
  // enabling goes through a flush as well
  assign goto_flush  = flush_d | (en_i & ~cache_en_q);

  assign busy_o = (state_q != IDLE);

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    cache_en_d    = cache_en_q & en_i;
    flush_d       = flush_q | flush_i;
    flush_en      = 1'b0;
    rd_en         = 1'b0;
    wr_en         = 1'b0;
    cmp_en_d      = 1'b0;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;

    unique case (state_q)
      // clear one set of valid bits per cycle
      FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        if (goto_flush) begin
          state_d = FLUSH;
        end else if (!mem_rtrn_vld_i) begin
          // the array port is free only without a return beat
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            rd_en    = 1'b1;
            cmp_en_d = 1'b1;
            state_d  = READ;
          end
        end
      end
      READ: begin
        if (cmp_en_q && inv_q) begin
          // read data may be stale so look again
          rd_en    = 1'b1;
          cmp_en_d = 1'b1;
        end else if (cmp_en_q && hit_i && !nc_q) begin
          fetch_valid_o = 1'b1;
          state_d       = IDLE;
          // back to back hits
          if (!goto_flush && !mem_rtrn_vld_i) begin
            fetch_ready_o = 1'b1;
            if (fetch_req_i) begin
              rd_en    = 1'b1;
              cmp_en_d = 1'b1;
              state_d  = READ;
            end
          end
        end else begin
          // miss or nc fetch
          // request stays up until acked
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~nc_q;
            state_d = MISS;
          end
        end
      end
      MISS: begin
        // nc data is never written
        if (ifill_vld) begin
          fetch_valid_o = 1'b1;
          wr_en         = ~nc_q;
          state_d       = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // array controls and refill request
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    arr_ctrl_o.rd_en     = rd_en;
    arr_ctrl_o.wr_en     = wr_en;
    arr_ctrl_o.flush_en  = flush_en;
    arr_ctrl_o.inv_en    = inv_en;
    arr_ctrl_o.cmp_en    = cmp_en_q;
    // read index follows a new request in its own cycle
    arr_ctrl_o.index     = paddr_d[TagLsb-1:`ICACHE_OFFSET_WIDTH];
    arr_ctrl_o.tag       = paddr_q[`ICACHE_PADDR_WIDTH-1:TagLsb];
    arr_ctrl_o.offset    = paddr_q[`ICACHE_OFFSET_WIDTH-1:0];
    arr_ctrl_o.flush_idx = flush_cnt_q;
  end

  assign mem_req_data_o.paddr = nc_q ? (paddr_q & ~paddr_t'(3)) :
                                       (paddr_q & ~paddr_t'(`ICACHE_LINE_BYTES - 1));
  assign mem_req_data_o.nc    = nc_q;
  assign mem_req_data_o.way   = repl_way_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      cmp_en_q    <= 1'b0;
      inv_q       <= 1'b0;
      nc_q        <= 1'b0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
      cmp_en_q    <= cmp_en_d;
      inv_q       <= inv_en;
      nc_q        <= nc_d;
    end
  end

  // fetch address
  always_ff @(posedge clk_i) begin
    paddr_q <= paddr_d;
  end

endmodule

//--- source/icache_repl.sv
////////////////////////////////////////////////////////////////////////////
// replacement way choice from first invalid way or a random LFSR way
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "icache_defines.svh"

module icache_repl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  icache_pkg::arr_ctrl_t arr_ctrl_i,
  input  icache_pkg::way_vec_t  vld_ways_i,
  output icache_pkg::way_idx_t  repl_way_o,
  output icache_pkg::way_vec_t  repl_way_oh_o
);

  import icache_pkg::*;

  logic [`ICACHE_LFSR_WIDTH-1:0] lfsr_d, lfsr_q;
  logic                          all_valid;
  logic                          lfsr_upd;
  way_idx_t                      inv_way;
  way_idx_t                      repl_way_d, repl_way_q;

  assign all_valid = &vld_ways_i;

  // lowest numbered invalid way wins
  always_comb begin
    inv_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!vld_ways_i[w]) begin
        inv_way = way_idx_t'(w);
      end
    end
  end

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_d   = {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
  // only a fill into a full set moves it on
  assign lfsr_upd = arr_ctrl_i.wr_en & all_valid;

  assign repl_way_d    = all_valid ? lfsr_q[`ICACHE_WAY_WIDTH-1:0] : inv_way;
  // request sees the new choice already in the compare cycle
  assign repl_way_o    = arr_ctrl_i.cmp_en ? repl_way_d : repl_way_q;
  assign repl_way_oh_o = way_vec_t'(1) << repl_way_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q     <= '1;
      repl_way_q <= '0;
    end else begin
      if (lfsr_upd) begin
        lfsr_q <= lfsr_d;
      end
      if (arr_ctrl_i.cmp_en) begin
        repl_way_q <= repl_way_d;
      end
    end
  end

endmodule

//--- source/icache_array.sv
////////////////////////////////////////////////////////////////////////////
// tag, valid and data storage with tag compare and word select
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "icache_defines.svh"

module icache_array (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  icache_pkg::arr_ctrl_t     arr_ctrl_i,
  input  icache_pkg::way_vec_t      repl_way_oh_i,
  input  icache_mem_pkg::mem_rtrn_t mem_rtrn_i,
  output logic                      hit_o,
  output icache_pkg::way_vec_t      vld_ways_o,
  output icache_pkg::word_t         fetch_data_o
);

  import icache_pkg::*;

  localparam int unsigned ByteSel   = $clog2(`ICACHE_FETCH_WIDTH / 8);
  localparam int unsigned WordShift = $clog2(`ICACHE_FETCH_WIDTH);

  // storage per way and set
  tag_t     tag_mem  [`ICACHE_WAYS][`ICACHE_SETS];
  logic     vld_mem  [`ICACHE_WAYS][`ICACHE_SETS];
  line_t    data_mem [`ICACHE_WAYS][`ICACHE_SETS];

  // synchronous read outputs
  tag_t     rd_tag_q  [`ICACHE_WAYS];
  line_t    rd_data_q [`ICACHE_WAYS];
  way_vec_t rd_vld_q;

  index_t   vld_addr;
  way_vec_t vld_we_ways;
  logic     vld_wdata;
  way_vec_t inv_ways;
  way_vec_t hit_ways;
  way_idx_t hit_way;
  logic [$clog2(`ICACHE_LINE_WIDTH)-1:0] word_pos;

  ////////////////////////////////////////////////////////////////////////////
  // valid bit port
  ////////////////////////////////////////////////////////////////////////////

  assign inv_ways = mem_rtrn_i.inv_all ? '1 :
                    mem_rtrn_i.inv_one ? (way_vec_t'(1) << mem_rtrn_i.inv_way) : '0;

  // flush first then invalidation then normal access
  always_comb begin
    vld_addr    = arr_ctrl_i.index;
    vld_we_ways = '0;
    vld_wdata   = 1'b0;
    if (arr_ctrl_i.flush_en) begin
      vld_addr    = arr_ctrl_i.flush_idx;
      vld_we_ways = '1;
    end else if (arr_ctrl_i.inv_en) begin
      vld_addr    = mem_rtrn_i.inv_idx;
      vld_we_ways = inv_ways;
    end else if (arr_ctrl_i.wr_en) begin
      vld_we_ways = repl_way_oh_i;
      vld_wdata   = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (vld_we_ways[w]) begin
        vld_mem[w][vld_addr] <= vld_wdata;
      end
      // fill of the replacement way
      if (arr_ctrl_i.wr_en && repl_way_oh_i[w]) begin
        tag_mem[w][arr_ctrl_i.index]  <= arr_ctrl_i.tag;
        data_mem[w][arr_ctrl_i.index] <= mem_rtrn_i.data;
      end
      if (arr_ctrl_i.rd_en) begin
        rd_tag_q[w]  <= tag_mem[w][vld_addr];
        rd_data_q[w] <= data_mem[w][arr_ctrl_i.index];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_vld_q <= '0;
    end else if (arr_ctrl_i.rd_en) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        rd_vld_q[w] <= vld_mem[w][vld_addr];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tag compare and word select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hit_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      hit_ways[w] = rd_vld_q[w] & (rd_tag_q[w] == arr_ctrl_i.tag);
      if (hit_ways[w]) begin
        hit_way = way_idx_t'(w);
      end
    end
  end

  assign hit_o      = arr_ctrl_i.cmp_en & (|hit_ways);
  assign vld_ways_o = rd_vld_q;

  // bit position of the fetch word in the line
  assign word_pos = {arr_ctrl_i.offset[`ICACHE_OFFSET_WIDTH-1:ByteSel], {WordShift{1'b0}}};

  // refill word goes straight out when no compare is running
  assign fetch_data_o = arr_ctrl_i.cmp_en ?
                        rd_data_q[hit_way][word_pos +: `ICACHE_FETCH_WIDTH] :
                        mem_rtrn_i.data[word_pos +: `ICACHE_FETCH_WIDTH];

endmodule

//--- source/icache_top.sv
////////////////////////////////////////////////////////////////////////////
// instruction cache top with controller, arrays and replacement
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      en_i,
  input  logic                      flush_i,
  // fetch side
  input  logic                      fetch_req_i,
  input  icache_pkg::paddr_t        fetch_paddr_i,
  output logic                      fetch_ready_o,
  output logic                      fetch_valid_o,
  output icache_pkg::word_t         fetch_data_o,
  // refill side
  output logic                      mem_req_o,
  output icache_mem_pkg::mem_req_t  mem_req_data_o,
  input  logic                      mem_ack_i,
  input  logic                      mem_rtrn_vld_i,
  input  icache_mem_pkg::mem_rtrn_t mem_rtrn_i,
  // status
  output logic                      miss_o,
  output logic                      busy_o
);

  import icache_pkg::*;

  arr_ctrl_t arr_ctrl;
  logic      hit;
  way_vec_t  vld_ways;
  way_idx_t  repl_way;
  way_vec_t  repl_way_oh;

  icache_ctrl i_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .en_i           (en_i),
    .flush_i        (flush_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_paddr_i  (fetch_paddr_i),
    .hit_i          (hit),
    .repl_way_i     (repl_way),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .mem_rtrn_i     (mem_rtrn_i),
    .arr_ctrl_o     (arr_ctrl),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_valid_o  (fetch_valid_o),
    .mem_req_o      (mem_req_o),
    .mem_req_data_o (mem_req_data_o),
    .miss_o         (miss_o),
    .busy_o         (busy_o)
  );

  icache_array i_array (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .arr_ctrl_i    (arr_ctrl),
    .repl_way_oh_i (repl_way_oh),
    .mem_rtrn_i    (mem_rtrn_i),
    .hit_o         (hit),
    .vld_ways_o    (vld_ways),
    .fetch_data_o  (fetch_data_o)
  );

  icache_repl i_repl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .arr_ctrl_i    (arr_ctrl),
    .vld_ways_i    (vld_ways),
    .repl_way_o    (repl_way),
    .repl_way_oh_o (repl_way_oh)
  );

endmodule

//--- verification/icache_properties.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks on the cache ports, bound to the top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_properties (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     mem_req_o,
  input icache_mem_pkg::mem_req_t mem_req_data_o,
  input logic                     mem_ack_i,
  input logic                     miss_o,
  input logic                     fetch_valid_o,
  input logic                     busy_o
);

  // request and its payload held until acked
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_req_data_o))
    else $error("memory request dropped or changed before its ack");

  // miss pulse only in the ack cycle
  miss_with_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss_o |-> mem_ack_i)
    else $error("miss pulse without memory ack");

  // a fetch result always belongs to a busy controller
  valid_when_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_o |-> busy_o)
    else $error("fetch valid while controller idle");

endmodule

bind icache_top icache_properties props (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .mem_req_o      (mem_req_o),
  .mem_req_data_o (mem_req_data_o),
  .mem_ack_i      (mem_ack_i),
  .miss_o         (miss_o),
  .fetch_valid_o  (fetch_valid_o),
  .busy_o         (busy_o)
);

//--- verification/icache_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the instruction cache
// memory model, stimulus table, result checks and watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "icache_defines.svh"

module icache_tb;

  import icache_pkg::*;
  import icache_mem_pkg::*;

  localparam int unsigned ClkPeriod = 100;
  // flush and ack delay and the return beat plus some margin
  localparam int unsigned MaxFetchCycles = `ICACHE_SETS + 24;
  // way left to the LFSR or of no interest
  localparam int AnyWay = -1;

  typedef enum logic [1:0] {ACT_NONE, ACT_FLUSH, ACT_INV_ALL, ACT_INV_ONE} act_e;
  // MEM_ANY where the random way decides
  typedef enum logic [1:0] {MEM_NO, MEM_YES, MEM_ANY} mem_exp_e;

  typedef struct packed {
    paddr_t   addr;
    logic     en;
    act_e     act;
    mem_exp_e mem;
    int       way;
  } entry_t;

  logic      clk_i;
  logic      rst_ni;
  logic      en_i;
  logic      flush_i;
  logic      fetch_req_i;
  paddr_t    fetch_paddr_i;
  logic      fetch_ready_o;
  logic      fetch_valid_o;
  word_t     fetch_data_o;
  logic      mem_req_o;
  mem_req_t  mem_req_data_o;
  logic      mem_ack_i;
  logic      mem_rtrn_vld_i;
  mem_rtrn_t mem_rtrn_i;
  logic      miss_o;
  logic      busy_o;

  string       names[$];
  entry_t      entries[$];
  logic        table_ready;
  logic [31:0] rng_state;

  icache_top dut (.*);

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // memory contents and helpers
  ////////////////////////////////////////////////////////////////////////////

  // each word depends on its own byte address
  function automatic word_t mem_word(paddr_t a);
    return {a ^ 16'h5a5a, ~a};
  endfunction

  function automatic line_t mem_line(paddr_t base);
    line_t l;
    for (int i = 0; i < `ICACHE_LINE_BYTES / 4; i++) begin
      l[i*32 +: 32] = mem_word(paddr_t'(base + paddr_t'(4 * i)));
    end
    return l;
  endfunction

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic mem_rtrn_t fill_beat(paddr_t req_addr);
    mem_rtrn_t b;
    b       = '0;
    b.rtype = IFILL;
    b.data  = mem_line(req_addr & ~paddr_t'(`ICACHE_LINE_BYTES - 1));
    return b;
  endfunction

  // invalidation of the set that holds the entry address
  // a one way invalidation always hits way 0
  function automatic mem_rtrn_t inv_beat(entry_t e);
    mem_rtrn_t b;
    b         = '0;
    b.rtype   = INV;
    b.inv_all = (e.act == ACT_INV_ALL);
    b.inv_one = (e.act == ACT_INV_ONE);
    b.inv_idx = index_t'(e.addr >> `ICACHE_OFFSET_WIDTH);
    return b;
  endfunction

  task automatic fail_run(string msg);
    $display("ERROR: %s", msg);
    $display("Testbench failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(string name, string what, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      $display("FAIL %s: %s expected %h actual %h", name, what, exp, act);
      $display("Testbench failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic add_entry(string name, paddr_t addr, logic en, act_e act, mem_exp_e mem,
                           int way);
    entry_t e;
    e.addr = addr;
    e.en   = en;
    e.act  = act;
    e.mem  = mem;
    e.way  = way;
    names.push_back(name);
    entries.push_back(e);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    add_entry("first_fill",   16'h0124, 1'b1, ACT_NONE,    MEM_YES, 0);
    add_entry("same_word",    16'h0124, 1'b1, ACT_NONE,    MEM_NO,  AnyWay);
    add_entry("same_line",    16'h0128, 1'b1, ACT_NONE,    MEM_NO,  AnyWay);
    add_entry("line_end",     16'h012c, 1'b1, ACT_NONE,    MEM_NO,  AnyWay);
    add_entry("nc_first",     16'h8130, 1'b1, ACT_NONE,    MEM_YES, AnyWay);
    add_entry("nc_again",     16'h8130, 1'b1, ACT_NONE,    MEM_YES, AnyWay);
    add_entry("other_line",   16'h0240, 1'b1, ACT_NONE,    MEM_YES, 0);
    add_entry("other_hit",    16'h0244, 1'b1, ACT_NONE,    MEM_NO,  AnyWay);
    add_entry("inv_all",      16'h0120, 1'b1, ACT_INV_ALL, MEM_YES, 0);
    add_entry("after_inv",    16'h0124, 1'b1, ACT_NONE,    MEM_NO,  AnyWay);
    add_entry("flush_pulse",  16'h0240, 1'b1, ACT_FLUSH,   MEM_YES, 0);
    add_entry("flush_other",  16'h0124, 1'b1, ACT_NONE,    MEM_YES, 0);
    add_entry("disabled_a",   16'h0124, 1'b0, ACT_NONE,    MEM_YES, AnyWay);
    add_entry("disabled_b",   16'h0124, 1'b0, ACT_NONE,    MEM_YES, AnyWay);
    add_entry("reenable",     16'h0124, 1'b1, ACT_NONE,    MEM_YES, 0);
    // set 2 holds one line after the enable flush and it sits in way 0
    add_entry("inv_one",      16'h0120, 1'b1, ACT_INV_ONE, MEM_YES, 0);
    // six lines into set 5 and each one fetched twice
    // the set is empty here so the first four fill ways 0 to 3
    add_entry("set5_a_miss",  16'h1050, 1'b1, ACT_NONE,    MEM_YES, 0);
    add_entry("set5_a_hit",   16'h1054, 1'b1, ACT_NONE,    MEM_NO,  AnyWay);
    add_entry("set5_b_miss",  16'h1154, 1'b1, ACT_NONE,    MEM_YES, 1);
    add_entry("set5_b_hit",   16'h1154, 1'b1, ACT_NONE,    MEM_NO,  AnyWay);
    add_entry("set5_c_miss",  16'h1258, 1'b1, ACT_NONE,    MEM_YES, 2);
    add_entry("set5_c_hit",   16'h125c, 1'b1, ACT_NONE,    MEM_NO,  AnyWay);
    add_entry("set5_d_miss",  16'h1358, 1'b1, ACT_NONE,    MEM_YES, 3);
    add_entry("set5_d_hit",   16'h1350, 1'b1, ACT_NONE,    MEM_NO,  AnyWay);
    add_entry("set5_e_miss",  16'h1454, 1'b1, ACT_NONE,    MEM_YES, AnyWay);
    add_entry("set5_e_hit",   16'h1458, 1'b1, ACT_NONE,    MEM_NO,  AnyWay);
    add_entry("set5_f_miss",  16'h1550, 1'b1, ACT_NONE,    MEM_YES, AnyWay);
    add_entry("set5_f_hit",   16'h155c, 1'b1, ACT_NONE,    MEM_NO,  AnyWay);
    // second pass where the random way decides hit or miss
    add_entry("set5_a_again", 16'h1058, 1'b1, ACT_NONE,    MEM_ANY, AnyWay);
    add_entry("set5_c_again", 16'h1250, 1'b1, ACT_NONE,    MEM_ANY, AnyWay);
    add_entry("set5_e_again", 16'h145c, 1'b1, ACT_NONE,    MEM_ANY, AnyWay);
    add_entry("set5_f_again", 16'h1554, 1'b1, ACT_NONE,    MEM_ANY, AnyWay);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sequences
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_reset_flush();
    int busy_cycles;
    busy_cycles = 0;
    @(negedge clk_i);
    while (busy_o) begin
      busy_cycles++;
      if (busy_cycles > MaxFetchCycles) fail_run("busy_o stuck high after reset");
      @(negedge clk_i);
    end
    check_value("reset_flush", "busy cycles", 32'(`ICACHE_SETS), 32'(busy_cycles));
  endtask

  task automatic wait_ready(string name);
    int cyc;
    cyc = 0;
    @(negedge clk_i);
    while (!fetch_ready_o) begin
      cyc++;
      if (cyc > MaxFetchCycles) fail_run({name, ": cache never became ready"});
      @(negedge clk_i);
    end
  endtask

  task automatic run_entry(string name, entry_t e);
    int       cyc;
    int       wait_ack;
    int       phase;
    int       reqs;
    int       misses;
    logic     saw_req;
    logic     exp_nc;
    paddr_t   req_addr;
    paddr_t   exp_req;
    way_idx_t req_way;
    // enable level and the action ahead of the fetch
    @(posedge clk_i);
    en_i <= e.en;
    case (e.act)
      ACT_FLUSH: flush_i <= 1'b1;
      ACT_INV_ALL, ACT_INV_ONE: begin
        mem_rtrn_vld_i <= 1'b1;
        mem_rtrn_i     <= inv_beat(e);
      end
      default: ;
    endcase
    @(posedge clk_i);
    flush_i        <= 1'b0;
    mem_rtrn_vld_i <= 1'b0;
    wait_ready(name);
    @(posedge clk_i);
    fetch_req_i   <= 1'b1;
    fetch_paddr_i <= e.addr;
    wait_ready(name);
    // request taken at this edge
    @(posedge clk_i);
    fetch_req_i <= 1'b0;

    exp_nc    = e.addr[`ICACHE_PADDR_WIDTH-1] | ~e.en;
    rng_state = xorshift(rng_state);
    wait_ack  = int'(rng_state % 4);
    cyc       = 0;
    phase     = 0;
    reqs      = 0;
    misses    = 0;
    req_addr  = '0;
    req_way   = '0;
    forever begin
      @(negedge clk_i);
      cyc++;
      if (fetch_valid_o) break;
      if (phase == 2) fail_run({name, ": no fetch_valid_o with the fill beat"});
      if (cyc > MaxFetchCycles) fail_run({name, ": no fetch_valid_o before timeout"});
      saw_req = mem_req_o;
      // ack cycle
      if (phase == 1) begin
        reqs++;
        if (miss_o) misses++;
        req_addr = mem_req_data_o.paddr;
        req_way  = mem_req_data_o.way;
        check_value(name, "request nc", 32'(exp_nc), 32'(mem_req_data_o.nc));
      end
      @(posedge clk_i);
      mem_ack_i <= 1'b0;
      if (phase == 0 && saw_req) begin
        if (wait_ack == 0) begin
          mem_ack_i <= 1'b1;
          phase = 1;
        end else begin
          wait_ack--;
        end
      end else if (phase == 1) begin
        mem_rtrn_vld_i <= 1'b1;
        mem_rtrn_i     <= fill_beat(req_addr);
        phase = 2;
      end
    end
    check_value(name, "fetch data", mem_word(e.addr & ~paddr_t'(3)), fetch_data_o);
    @(posedge clk_i);
    mem_rtrn_vld_i <= 1'b0;
    mem_ack_i      <= 1'b0;

    if (e.mem == MEM_NO) begin
      check_value(name, "memory requests", 32'd0, 32'(reqs));
      check_value(name, "hit latency", 32'd1, 32'(cyc));
    end else if (e.mem == MEM_YES) begin
      check_value(name, "memory requests", 32'd1, 32'(reqs));
    end
    if (reqs != 0) begin
      exp_req = exp_nc ? (e.addr & ~paddr_t'(3)) :
                         (e.addr & ~paddr_t'(`ICACHE_LINE_BYTES - 1));
      check_value(name, "request address", 32'(exp_req), 32'(req_addr));
      check_value(name, "miss pulses", 32'(!exp_nc), 32'(misses));
      // first invalid way of the set
      if (!exp_nc && e.way != AnyWay) begin
        check_value(name, "replacement way", 32'(e.way), 32'(req_way));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni         = 1'b0;
    en_i           = 1'b1;
    flush_i        = 1'b0;
    fetch_req_i    = 1'b0;
    fetch_paddr_i  = '0;
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_i     = '0;
    rng_state      = 32'hd795_c443;
    table_ready    = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_reset_flush();
    foreach (entries[i]) begin
      run_entry(names[i], entries[i]);
    end
    $display("Testbench passed");
    $finish;
  end

  // each entry may wait for a flush and then for a slow miss
  initial begin
    wait (table_ready);
    repeat ((entries.size() + 2) * MaxFetchCycles * 3) @(posedge clk_i);
    $display("ERROR: watchdog expired before the tests finished");
    $display("Testbench failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

//--- list.f
+incdir+source
source/icache_pkg.sv
source/icache_mem_pkg.sv
source/icache_ctrl.sv
source/icache_repl.sv
source/icache_array.sv
source/icache_top.sv
verification/icache_properties.sv
verification/icache_tb.sv

//--- Makefile
TOP := icache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
